// File: common/machine_mode_pkg.sv
// Machine mode privilege types
`default_nettype none

package machine_mode_pkg;

  typedef logic [31:0] word_t;

  // Machine CSR addresses, priv spec 1.7 map
  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MTVEC    = 12'h301,
    CSR_MTDELEG  = 12'h302,
    CSR_MIE      = 12'h304,
    CSR_MTIMECMP = 12'h321,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MBADADDR = 12'h343,
    CSR_MIP      = 12'h344,
    CSR_MTIME    = 12'h701,
    CSR_MCPUID   = 12'hf00,
    CSR_MIMPID   = 12'hf01,
    CSR_MHARTID  = 12'hf10
  } csr_addr_t;

  // Machine privilege level encoding
  localparam logic [1:0] PRV_M = 2'b11;

  // Only ie and ie1 are live, the stack below stays in M
  typedef struct packed {
    logic [19:0] zero;
    logic [1:0]  prv3;
    logic        ie3;
    logic [1:0]  prv2;
    logic        ie2;
    logic [1:0]  prv1;
    logic        ie1;
    logic [1:0]  prv;
    logic        ie;
  } mstatus_t;

  typedef struct packed {
    logic [23:0] zero_1;
    logic        mtie;
    logic [2:0]  zero_0;
    logic        msie;
    logic [2:0]  zero;
  } mie_t;

  typedef struct packed {
    logic [23:0] zero_1;
    logic        mtip;
    logic [2:0]  zero_0;
    logic        msip;
    logic [2:0]  zero;
  } mip_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } mcause_t;

  // Exception codes, interrupt flag clear
  typedef enum logic [30:0] {
    EXC_FETCH_MISALIGN = 31'd0,
    EXC_ILLEGAL_INSN   = 31'd2,
    EXC_BREAKPOINT     = 31'd3,
    EXC_ECALL_M        = 31'd11
  } exc_code_t;

  // Interrupt codes share value 3 with breakpoint, hence their own enum
  typedef enum logic [30:0] {
    INT_SOFT  = 31'd3,
    INT_TIMER = 31'd7
  } int_code_t;

  typedef struct packed {
    logic        swap;
    logic        set;
    logic        clr;
    logic [11:0] addr;
    word_t       wdata;
  } csr_req_t;

  typedef struct packed {
    logic  fetch_misalign;
    logic  illegal;
    logic  ebreak;
    logic  ecall;
    word_t epc;
    word_t badaddr;
  } exc_req_t;

  typedef struct packed {
    logic    save;
    logic    restore;
    word_t   mepc;
    mcause_t mcause;
    word_t   mbadaddr;
  } trap_wr_t;

  typedef enum logic [1:0] {
    IDLE,
    SAVE,
    JUMP,
    RETURN
  } trap_state_t;

  // mcpuid fields
  localparam logic [1:0]  BASE_RV32 = 2'b00;
  localparam logic [25:0] EXT_I     = 26'h100;

endpackage

`default_nettype wire

// File: priv/machine_timer.sv
// Machine timer and compare
`timescale 1ns/1ns
`default_nettype none

module machine_timer import machine_mode_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  tcmp_we,
  input  word_t tcmp_wdata,
  output word_t mtime,
  output word_t mtimecmp,
  output logic  timer_int
);

  // Free-running, wraps at 2^32
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      mtime <= '0;
    else
      mtime <= mtime + 32'd1;
  end

  // Compare starts at max so nothing fires out of reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      mtimecmp <= '1;
    else if (tcmp_we)
      mtimecmp <= tcmp_wdata;
  end

  // Level, stays up until mtimecmp moves past mtime
  assign timer_int = (mtime >= mtimecmp);

endmodule

`default_nettype wire

// File: priv/trap_cause_sel.sv
// Trap cause priority encoder
`timescale 1ns/1ns
`default_nettype none

module trap_cause_sel import machine_mode_pkg::*; (
  input  exc_req_t exc_req,
  input  mstatus_t mstatus,
  input  mie_t     mie,
  input  mip_t     mip,
  output logic     trap_valid,
  output mcause_t  trap_cause
);

  logic timer_pend, soft_pend;

  // Interrupt must be globally enabled, enabled and pending
  assign timer_pend = mstatus.ie & mie.mtie & mip.mtip;
  assign soft_pend  = mstatus.ie & mie.msie & mip.msip;

  always_comb begin
    trap_valid = 1'b1;
    trap_cause = '0;
    // Fixed order, exceptions first
    if (exc_req.fetch_misalign)
      trap_cause.code = EXC_FETCH_MISALIGN;
    else if (exc_req.illegal)
      trap_cause.code = EXC_ILLEGAL_INSN;
    else if (exc_req.ebreak)
      trap_cause.code = EXC_BREAKPOINT;
    else if (exc_req.ecall)
      trap_cause.code = EXC_ECALL_M;
    else if (timer_pend) begin
      trap_cause.interrupt = 1'b1;
      trap_cause.code      = INT_TIMER;
    end else if (soft_pend) begin
      trap_cause.interrupt = 1'b1;
      trap_cause.code      = INT_SOFT;
    end else
      trap_valid = 1'b0;
  end

endmodule

`default_nettype wire

// File: priv/trap_ctrl.sv
// Trap entry and return sequencer
`timescale 1ns/1ns
`default_nettype none

module trap_ctrl import machine_mode_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     trap_valid,
  input  mcause_t  trap_cause,
  input  exc_req_t exc_req,
  input  logic     eret,
  input  word_t    mtvec,
  input  word_t    mepc,
  output trap_wr_t trap_wr,
  output logic     insert_pc,
  output word_t    priv_pc
);

  trap_state_t state, state_next;

  // Values captured at the trap boundary
  mcause_t cause_q;
  word_t   epc_q;
  word_t   badaddr_q;
  logic    take_trap;
  logic    take_eret;

  // Exceptions beat eret and eret beats interrupts
  assign take_eret = (state == IDLE) && eret && (!trap_valid || trap_cause.interrupt);
  // Only IDLE looks at requests
  assign take_trap = (state == IDLE) && trap_valid && !take_eret;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (take_trap)
          state_next = SAVE;
        else if (take_eret)
          state_next = RETURN;
      end
      SAVE:    state_next = JUMP;
      JUMP:    state_next = IDLE;
      RETURN:  state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      state <= IDLE;
    else
      state <= state_next;
  end

  // Capture cause and addresses on entry
  always_ff @(posedge CLK) begin
    if (take_trap) begin
      cause_q   <= trap_cause;
      epc_q     <= exc_req.epc;
      // badaddr only meaningful for a misaligned fetch
      badaddr_q <= exc_req.fetch_misalign ? exc_req.badaddr : '0;
    end
  end

  always_comb begin
    trap_wr          = '0;
    trap_wr.save     = (state == SAVE);
    trap_wr.restore  = (state == RETURN);
    trap_wr.mepc     = epc_q;
    trap_wr.mcause   = cause_q;
    trap_wr.mbadaddr = badaddr_q;
  end

  // Redirect to the handler or back to mepc
  assign insert_pc = (state == JUMP) || (state == RETURN);
  assign priv_pc   = (state == RETURN) ? mepc : mtvec;

endmodule

`default_nettype wire

// File: priv/csr_rfile.sv
// Machine CSR register file
`timescale 1ns/1ns
`default_nettype none

module csr_rfile import machine_mode_pkg::*; #(
  parameter word_t MTVEC_ADDR = 32'h100,
  parameter word_t HART_ID    = 32'h0
) (
  input  logic     CLK,
  input  logic     nRST,
  input  csr_req_t csr_req,
  input  trap_wr_t trap_wr,
  input  logic     msip_in,
  input  word_t    mtime,
  input  word_t    mtimecmp,
  input  logic     timer_int,
  output word_t    rdata,
  output logic     invalid_csr,
  output logic     tcmp_we,
  output word_t    tcmp_wdata,
  output word_t    mtvec,
  output word_t    mepc,
  output mstatus_t mstatus,
  output mie_t     mie,
  output mip_t     mip
);

  // Live state bits
  logic    ie, ie1;
  logic    msie, mtie;
  word_t   mscratch;
  mcause_t mcause;
  word_t   mbadaddr;

  // Pipeline access decode
  logic  csr_op;
  logic  valid_addr;
  word_t rup_data;
  word_t mcpuid;

  assign mcpuid = {BASE_RV32, 4'b0, EXT_I};
  assign mtvec  = MTVEC_ADDR;

  // Assemble the architectural views, dead fields fixed
  always_comb begin
    mstatus      = '0;
    mstatus.prv  = PRV_M;
    mstatus.prv1 = PRV_M;
    mstatus.prv2 = PRV_M;
    mstatus.prv3 = PRV_M;
    mstatus.ie   = ie;
    mstatus.ie1  = ie1;
    mie          = '0;
    mie.msie     = msie;
    mie.mtie     = mtie;
    mip          = '0;
    mip.msip     = msip_in;
    mip.mtip     = timer_int;
  end

  assign csr_op      = csr_req.swap | csr_req.set | csr_req.clr;
  assign invalid_csr = csr_op & ~valid_addr;

  // Read-modify-write value, set is the fall-through
  assign rup_data = csr_req.swap ? csr_req.wdata :
                    csr_req.clr  ? (rdata & ~csr_req.wdata) :
                                   (rdata | csr_req.wdata);

  // Read mux, combinational
  always_comb begin
    valid_addr = 1'b1;
    case (csr_req.addr)
      CSR_MCPUID:   rdata = mcpuid;
      CSR_MIMPID:   rdata = '0;
      CSR_MHARTID:  rdata = HART_ID;
      CSR_MSTATUS:  rdata = mstatus;
      CSR_MTVEC:    rdata = mtvec;
      CSR_MTDELEG:  rdata = '0;
      CSR_MIE:      rdata = mie;
      CSR_MTIMECMP: rdata = mtimecmp;
      CSR_MSCRATCH: rdata = mscratch;
      CSR_MEPC:     rdata = mepc;
      CSR_MCAUSE:   rdata = mcause;
      CSR_MBADADDR: rdata = mbadaddr;
      CSR_MIP:      rdata = mip;
      CSR_MTIME:    rdata = mtime;
      // Protection, lower modes, other counters and host regs are absent
      12'h380, 12'h381, 12'h382, 12'h383, 12'h384, 12'h385,
      12'hb01, 12'hb81, 12'h741, 12'h780, 12'h781: rdata = '0;
      default: begin
        valid_addr = 1'b0;
        rdata      = '0;
      end
    endcase
  end

  // mtimecmp lives in the timer
  assign tcmp_we    = csr_op && (csr_req.addr == CSR_MTIMECMP);
  assign tcmp_wdata = rup_data;

  // mstatus, trap stacking wins over pipeline writes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ie  <= 1'b1;
      ie1 <= 1'b0;
    end else if (trap_wr.save) begin
      ie1 <= ie;
      ie  <= 1'b0;
    end else if (trap_wr.restore) begin
      ie  <= ie1;
      ie1 <= 1'b1;
    end else if (csr_op && (csr_req.addr == CSR_MSTATUS)) begin
      ie  <= rup_data[0];
      ie1 <= rup_data[3];
    end
  end

  // Trap handling registers, read-only to the pipeline
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mepc     <= '0;
      mcause   <= '0;
      mbadaddr <= '0;
    end else if (trap_wr.save) begin
      mepc     <= trap_wr.mepc;
      mcause   <= trap_wr.mcause;
      mbadaddr <= trap_wr.mbadaddr;
    end
  end

  // Pipeline-only registers
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      msie     <= 1'b0;
      mtie     <= 1'b0;
      mscratch <= '0;
    end else if (csr_op) begin
      if (csr_req.addr == CSR_MIE) begin
        msie <= rup_data[3];
        mtie <= rup_data[7];
      end
      if (csr_req.addr == CSR_MSCRATCH)
        mscratch <= rup_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/priv_unit.sv
// Machine mode privilege unit
`timescale 1ns/1ns
`default_nettype none

module priv_unit import machine_mode_pkg::*; #(
  parameter word_t MTVEC_ADDR = 32'h100,
  parameter word_t HART_ID    = 32'h0
) (
  input  logic     CLK,
  input  logic     nRST,
  input  csr_req_t csr_req,
  input  exc_req_t exc_req,
  input  logic     eret,
  input  logic     msip_in,
  output word_t    rdata,
  output logic     invalid_csr,
  output logic     insert_pc,
  output word_t    priv_pc
);

  // CSR state toward the trap logic
  word_t    mtvec, mepc;
  mstatus_t mstatus;
  mie_t     mie;
  mip_t     mip;

  // Trap path
  logic     trap_valid;
  mcause_t  trap_cause;
  trap_wr_t trap_wr;

  // Timer path
  word_t mtime, mtimecmp, tcmp_wdata;
  logic  timer_int, tcmp_we;

  csr_rfile #(
    .MTVEC_ADDR (MTVEC_ADDR),
    .HART_ID    (HART_ID)
  ) u_csr_rfile (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_req     (csr_req),
    .trap_wr     (trap_wr),
    .msip_in     (msip_in),
    .mtime       (mtime),
    .mtimecmp    (mtimecmp),
    .timer_int   (timer_int),
    .rdata       (rdata),
    .invalid_csr (invalid_csr),
    .tcmp_we     (tcmp_we),
    .tcmp_wdata  (tcmp_wdata),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mstatus     (mstatus),
    .mie         (mie),
    .mip         (mip)
  );

  trap_cause_sel u_trap_cause_sel (
    .exc_req    (exc_req),
    .mstatus    (mstatus),
    .mie        (mie),
    .mip        (mip),
    .trap_valid (trap_valid),
    .trap_cause (trap_cause)
  );

  trap_ctrl u_trap_ctrl (
    .CLK        (CLK),
    .nRST       (nRST),
    .trap_valid (trap_valid),
    .trap_cause (trap_cause),
    .exc_req    (exc_req),
    .eret       (eret),
    .mtvec      (mtvec),
    .mepc       (mepc),
    .trap_wr    (trap_wr),
    .insert_pc  (insert_pc),
    .priv_pc    (priv_pc)
  );

  machine_timer u_machine_timer (
    .CLK        (CLK),
    .nRST       (nRST),
    .tcmp_we    (tcmp_we),
    .tcmp_wdata (tcmp_wdata),
    .mtime      (mtime),
    .mtimecmp   (mtimecmp),
    .timer_int  (timer_int)
  );

endmodule

`default_nettype wire

// File: tests/priv_unit_props.sv
// Trap sequencer assertions
`timescale 1ns/1ns
`default_nettype none

module priv_unit_props (
  input logic CLK,
  input logic nRST,
  input logic insert_pc,
  input logic save
);

  // Redirect is a single-cycle pulse
  a_single_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    insert_pc |=> !insert_pc)
    else $error("insert_pc high for two cycles in a row");

  // SAVE always hands over to JUMP
  a_save_then_jump: assert property (@(posedge CLK) disable iff (!nRST)
    save |=> insert_pc)
    else $error("save not followed by insert_pc");

  a_quiet_in_reset: assert property (@(posedge CLK) !nRST |-> !insert_pc)
    else $error("insert_pc high during reset");

endmodule

bind trap_ctrl priv_unit_props u_props (
  .CLK       (CLK),
  .nRST      (nRST),
  .insert_pc (insert_pc),
  .save      (trap_wr.save)
);

`default_nettype wire

// File: tests/priv_unit_tb.sv
// Privilege unit testbench
`timescale 1ns/1ns
`default_nettype none

module priv_unit_tb import machine_mode_pkg::*; ();

  localparam word_t MTVEC_ADDR     = 32'h0000_0200;
  localparam word_t HART_ID        = 32'h0000_0003;
  localparam int    TIMEOUT_CYCLES = 4000;
  // Writable bits of mie, msie and mtie
  localparam word_t MIE_LIVE       = 32'h0000_0088;
  localparam int    OP_SWAP        = 0;
  localparam int    OP_SET         = 1;
  localparam int    OP_CLR         = 2;

  logic     CLK;
  logic     nRST;
  csr_req_t csr_req;
  exc_req_t exc_req;
  logic     eret;
  logic     msip_in;
  word_t    rdata;
  logic     invalid_csr;
  logic     insert_pc;
  word_t    priv_pc;

  // Expectations posted by the stimulus
  logic  rd_chk, exp_inv, pc_chk, exp_insert;
  word_t exp_rdata, exp_target;

  // Bookkeeping
  word_t  ticks;
  int     cmp_errors, stim_errors, err_mark, tests_run, tests_failed, cycles;
  integer seed;

  priv_unit #(
    .MTVEC_ADDR (MTVEC_ADDR),
    .HART_ID    (HART_ID)
  ) dut (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_req     (csr_req),
    .exc_req     (exc_req),
    .eret        (eret),
    .msip_in     (msip_in),
    .rdata       (rdata),
    .invalid_csr (invalid_csr),
    .insert_pc   (insert_pc),
    .priv_pc     (priv_pc)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // mtime model, counts every edge out of reset
  always @(posedge CLK) begin
    if (!nRST)
      ticks <= '0;
    else
      ticks <= ticks + 32'd1;
  end

  // Expected register value after one access
  function automatic word_t csr_apply(input word_t old, input int op, input word_t wdata);
    case (op)
      OP_SWAP: return wdata;
      OP_SET:  return old | wdata;
      default: return old & ~wdata;
    endcase
  endfunction

  function automatic logic [2:0] op_strobes(input int op);
    case (op)
      OP_SWAP: return 3'b100;
      OP_SET:  return 3'b010;
      default: return 3'b001;
    endcase
  endfunction

  // Four stack levels, every prv field reads machine mode
  function automatic word_t mstatus_val(input logic ie, input logic ie1);
    word_t v;
    v    = 32'h0000_0db6;
    v[0] = ie;
    v[3] = ie1;
    return v;
  endfunction

  task automatic show_mismatch(input string what, input word_t got, input word_t exp);
    $display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
  endtask

  // One access cycle, rdata and invalid_csr checked in that cycle
  task automatic csr_access(input logic [2:0] strb, input logic [11:0] addr,
                            input word_t wdata, input word_t exp, input logic exp_bad);
    csr_req_t req;
    req.swap  = strb[2];
    req.set   = strb[1];
    req.clr   = strb[0];
    req.addr  = addr;
    req.wdata = wdata;
    @(posedge CLK);
    csr_req   <= req;
    exp_rdata <= exp;
    exp_inv   <= exp_bad;
    rd_chk    <= 1'b1;
    @(posedge CLK);
    csr_req <= '0;
    rd_chk  <= 1'b0;
  endtask

  task automatic expect_csr(input logic [11:0] addr, input word_t exp);
    csr_access(3'b000, addr, '0, exp, 1'b0);
  endtask

  task automatic check_mtime(output word_t now);
    csr_req_t req;
    req      = '0;
    req.addr = CSR_MTIME;
    @(posedge CLK);
    csr_req <= req;
    @(negedge CLK);
    now = ticks;
    if (rdata !== ticks) begin
      show_mismatch("mtime", rdata, ticks);
      stim_errors++;
    end
    @(posedge CLK);
    csr_req <= '0;
  endtask

  // Caller drove the request at the last edge; redirect after lead cycles
  task automatic expect_pulse(input int lead);
    int i;
    for (i = 1; i < lead; i++) begin
      @(posedge CLK);
      exc_req    <= '0;
      eret       <= 1'b0;
      csr_req    <= '0;
      exp_insert <= 1'b0;
    end
    @(posedge CLK);
    exc_req    <= '0;
    eret       <= 1'b0;
    csr_req    <= '0;
    exp_insert <= 1'b1;
    @(posedge CLK);
    exp_insert <= 1'b0;
    @(posedge CLK);
    pc_chk <= 1'b0;
  endtask

  task automatic expect_quiet(input int n);
    @(posedge CLK);
    pc_chk     <= 1'b1;
    exp_insert <= 1'b0;
    repeat (n) @(posedge CLK);
    pc_chk <= 1'b0;
  endtask

  task automatic close_test(input string name);
    int errs;
    errs = cmp_errors + stim_errors - err_mark;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, errs);
      tests_failed++;
    end
    tests_run++;
    err_mark = cmp_errors + stim_errors;
  endtask

  // Comparing process, outputs settled by mid-cycle
  always @(negedge CLK) begin
    if (nRST) begin
      if (rd_chk) begin
        if (rdata !== exp_rdata) begin
          show_mismatch($sformatf("rdata at csr %h", csr_req.addr), rdata, exp_rdata);
          cmp_errors++;
        end
        if (invalid_csr !== exp_inv) begin
          show_mismatch("invalid_csr", {31'b0, invalid_csr}, {31'b0, exp_inv});
          cmp_errors++;
        end
      end
      if (pc_chk && (insert_pc !== exp_insert)) begin
        show_mismatch("insert_pc", {31'b0, insert_pc}, {31'b0, exp_insert});
        cmp_errors++;
      end
      if ((insert_pc === 1'b1) && (priv_pc !== exp_target)) begin
        show_mismatch("priv_pc", priv_pc, exp_target);
        cmp_errors++;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Run stopped after %0d cycles without reaching the end", cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int       op, i, k, n;
    word_t    wdata, m_scratch, m_mie, epc, bad, cause, target, now;
    exc_req_t ex;
    csr_req_t req;
    logic     found;
    seed = 34;
    cmp_errors = 0;
    stim_errors = 0;
    err_mark = 0;
    tests_run = 0;
    tests_failed = 0;
    nRST = 1'b0;
    csr_req = '0;
    exc_req = '0;
    eret = 1'b0;
    msip_in = 1'b0;
    rd_chk = 1'b0;
    exp_inv = 1'b0;
    pc_chk = 1'b0;
    exp_insert = 1'b0;
    exp_rdata = '0;
    exp_target = MTVEC_ADDR;
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;

    // Reset values and identification
    expect_csr(CSR_MSTATUS, mstatus_val(1'b1, 1'b0));
    expect_csr(CSR_MIE, 32'h0);
    expect_csr(CSR_MIP, 32'h0);
    expect_csr(CSR_MSCRATCH, 32'h0);
    expect_csr(CSR_MEPC, 32'h0);
    expect_csr(CSR_MCAUSE, 32'h0);
    expect_csr(CSR_MBADADDR, 32'h0);
    expect_csr(CSR_MTDELEG, 32'h0);
    expect_csr(CSR_MTIMECMP, 32'hffff_ffff);
    check_mtime(now);
    // RV32 base 0 in the top bits, I is extension bit 8
    expect_csr(CSR_MCPUID, 32'h0000_0100);
    expect_csr(CSR_MHARTID, HART_ID);
    expect_csr(CSR_MTVEC, MTVEC_ADDR);
    csr_access(3'b010, 12'h7c0, 32'hffff_ffff, 32'h0, 1'b1);
    close_test("reset_and_id");

    // Random swap, set and clear on mscratch and mie
    m_scratch = '0;
    m_mie = '0;
    for (i = 0; i < 32; i++) begin
      op = $unsigned($random(seed)) % 3;
      wdata = $random(seed);
      if ((i % 2) == 1) begin
        csr_access(op_strobes(op), CSR_MIE, wdata, m_mie, 1'b0);
        m_mie = csr_apply(m_mie, op, wdata) & MIE_LIVE;
        expect_csr(CSR_MIE, m_mie);
      end else begin
        csr_access(op_strobes(op), CSR_MSCRATCH, wdata, m_scratch, 1'b0);
        m_scratch = csr_apply(m_scratch, op, wdata);
        expect_csr(CSR_MSCRATCH, m_scratch);
      end
    end
    csr_access(3'b100, CSR_MIE, 32'h0, m_mie, 1'b0);
    // Trap registers are read-only to the pipeline
    csr_access(3'b100, CSR_MEPC, 32'hdead_beef, 32'h0, 1'b0);
    expect_csr(CSR_MEPC, 32'h0);
    csr_access(3'b100, CSR_MTVEC, 32'h0000_0abc, MTVEC_ADDR, 1'b0);
    expect_csr(CSR_MTVEC, MTVEC_ADDR);
    close_test("read_modify_write");

    // One trap per exception type
    for (k = 0; k < 4; k++) begin
      epc = $random(seed);
      bad = $random(seed);
      ex = '0;
      ex.epc = epc;
      ex.badaddr = bad;
      case (k)
        0: begin
          ex.fetch_misalign = 1'b1;
          cause = {1'b0, EXC_FETCH_MISALIGN};
        end
        1: begin
          ex.illegal = 1'b1;
          cause = {1'b0, EXC_ILLEGAL_INSN};
        end
        2: begin
          ex.ebreak = 1'b1;
          cause = {1'b0, EXC_BREAKPOINT};
        end
        default: begin
          ex.ecall = 1'b1;
          cause = {1'b0, EXC_ECALL_M};
        end
      endcase
      @(posedge CLK);
      exc_req    <= ex;
      pc_chk     <= 1'b1;
      exp_insert <= 1'b0;
      expect_pulse(2);
      expect_csr(CSR_MEPC, epc);
      expect_csr(CSR_MCAUSE, cause);
      expect_csr(CSR_MBADADDR, (k == 0) ? bad : 32'h0);
      expect_csr(CSR_MSTATUS, mstatus_val(1'b0, 1'b1));
      // Back to ie 1, ie1 0 for the next entry
      csr_access(3'b100, CSR_MSTATUS, 32'h1, mstatus_val(1'b0, 1'b1), 1'b0);
    end
    close_test("exception_entry");

    // mret returns to the saved pc
    epc = $random(seed);
    ex = '0;
    ex.ecall = 1'b1;
    ex.epc = epc;
    @(posedge CLK);
    exc_req    <= ex;
    pc_chk     <= 1'b1;
    exp_insert <= 1'b0;
    expect_pulse(2);
    @(posedge CLK);
    eret       <= 1'b1;
    exp_target <= epc;
    pc_chk     <= 1'b1;
    exp_insert <= 1'b0;
    expect_pulse(1);
    expect_csr(CSR_MSTATUS, mstatus_val(1'b1, 1'b1));
    @(posedge CLK);
    exp_target <= MTVEC_ADDR;
    close_test("mret");

    // Timer interrupt
    check_mtime(now);
    target = now + 32'd20;
    csr_access(3'b100, CSR_MTIMECMP, target, 32'hffff_ffff, 1'b0);
    csr_access(3'b010, CSR_MIE, 32'h80, 32'h0, 1'b0);
    found = 1'b0;
    n = 0;
    while (!found && (n < 30)) begin
      @(negedge CLK);
      if (insert_pc === 1'b1)
        found = 1'b1;
      n++;
    end
    if (!found) begin
      $display("Timer interrupt was not taken within 30 cycles");
      stim_errors++;
    end
    expect_csr(CSR_MCAUSE, {1'b1, 31'd7});
    // Still pending but ie is clear
    csr_access(3'b100, CSR_MSTATUS, 32'h0, mstatus_val(1'b0, 1'b1), 1'b0);
    expect_quiet(10);
    csr_access(3'b100, CSR_MTIMECMP, 32'hffff_ffff, target, 1'b0);
    csr_access(3'b100, CSR_MIE, 32'h0, 32'h80, 1'b0);
    csr_access(3'b100, CSR_MSTATUS, 32'h1, mstatus_val(1'b0, 1'b0), 1'b0);
    close_test("timer_interrupt");

    // Software interrupt needs msie and ie
    @(posedge CLK);
    msip_in <= 1'b1;
    expect_quiet(5);
    csr_access(3'b100, CSR_MSTATUS, 32'h0, mstatus_val(1'b1, 1'b0), 1'b0);
    csr_access(3'b010, CSR_MIE, 32'h8, 32'h0, 1'b0);
    expect_quiet(5);
    req = '0;
    req.set = 1'b1;
    req.addr = CSR_MSTATUS;
    req.wdata = 32'h1;
    @(posedge CLK);
    csr_req    <= req;
    pc_chk     <= 1'b1;
    exp_insert <= 1'b0;
    // Write lands, then trap seen, then redirect
    expect_pulse(3);
    expect_csr(CSR_MCAUSE, {1'b1, 31'd3});
    @(posedge CLK);
    msip_in <= 1'b0;
    csr_access(3'b100, CSR_MIE, 32'h0, 32'h8, 1'b0);
    close_test("software_interrupt");

    $display("tests run %0d, failed %0d, errors %0d",
             tests_run, tests_failed, cmp_errors + stim_errors);
    if ((cmp_errors + stim_errors) == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
common/machine_mode_pkg.sv
priv/machine_timer.sv
priv/trap_cause_sel.sv
priv/trap_ctrl.sv
priv/csr_rfile.sv
hdl/priv_unit.sv
tests/priv_unit_props.sv
tests/priv_unit_tb.sv

// File: Makefile
# Verilator flow for the privilege unit

TOP := priv_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ns --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f project.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf obj_dir
